// File: compile.f
src/ecc68_pkg.sv
src/ecc68_codec.sv
src/ecc_ram.sv
src/ecc_read_port.sv
src/ecc_err_log.sv
src/ecc_mem_top.sv
tb/tb_ecc_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ecc_mem \
    -f compile.f \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// File: src/ecc68_codec.sv
`timescale 1ns/100ps
`default_nettype none

module ecc68_codec (
    input  wire logic                               clk,
    input  wire logic [ecc68_pkg::DATA_WIDTH-1:0]   data_in,
    input  wire logic [ecc68_pkg::PARITY_WIDTH-1:0] parity_in,
    input  wire logic                               bypass,
    output logic      [ecc68_pkg::DATA_WIDTH-1:0]   data_out,
    output logic      [ecc68_pkg::PARITY_WIDTH-1:0] parity_out,
    output logic      [ecc68_pkg::DATA_WIDTH-1:0]   mask,
    output logic                                    sbit_err,
    output logic                                    dbit_err
);

    import ecc68_pkg::*;

    logic [PARITY_WIDTH-1:0] syndrome;
    logic                    sbit_raw;
    logic                    dbit_raw;

    // ==========================================================
    // syndrome
    // ==========================================================
    assign parity_out = ecc68_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;   // zero when the word is clean

    // ==========================================================
    // syndrome decode
    // ==========================================================
    always_comb begin
        mask     = '0;
        sbit_raw = 1'b0;
        dbit_raw = 1'b0;
        if (syndrome != '0) begin
            if ($onehot(syndrome)) begin
                sbit_raw = 1'b1;                      // check bit flipped, data intact
            end else begin
                dbit_raw = 1'b1;                      // assume double unless a column hits
                for (int i = 0; i < DATA_WIDTH; i++) begin
                    if (syndrome == H_COLUMNS[i]) begin
                        mask[i]  = 1'b1;
                        sbit_raw = 1'b1;
                        dbit_raw = 1'b0;
                    end
                end
            end
        end
    end

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : sbit_raw;
    assign dbit_err = bypass ? 1'b0 : dbit_raw;

    // ==========================================================
    // checks
    // ==========================================================
    // a syndrome decodes to one class only
    a_flags_exclusive: assert property (@(posedge clk) !(sbit_err && dbit_err));

    // correction never touches more than one data bit
    a_mask_onehot0: assert property (@(posedge clk) $onehot0(mask));

endmodule

`default_nettype wire

// File: src/ecc68_pkg.sv
`default_nettype none

package ecc68_pkg;

    // ==========================================================
    // widths and sizes
    // ==========================================================
    localparam int DATA_WIDTH   = 68;
    localparam int PARITY_WIDTH = 8;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH; // parity sits in the top bits
    localparam int ADDR_WIDTH   = 6;
    localparam int MEM_DEPTH    = 64;
    localparam int CNT_WIDTH    = 16;

    // ==========================================================
    // parity-check matrix, one column per data bit
    // ==========================================================
    // bit k of column i set => data bit i feeds parity bit k
    localparam logic [PARITY_WIDTH-1:0] H_COLUMNS [0:DATA_WIDTH-1] = '{
        8'h83, 8'h85, 8'h86, 8'h07,  // 0..3
        8'h89, 8'h8A, 8'h0B, 8'h8C,
        8'h0D, 8'h0E, 8'h8F, 8'h91,
        8'h92, 8'h13, 8'h94, 8'h15,
        8'h16, 8'h97, 8'h98, 8'h19,  // 16..19
        8'h1A, 8'h9B, 8'h1C, 8'h9D,
        8'h9E, 8'h1F, 8'hA1, 8'hA2,
        8'h23, 8'hA4, 8'h25, 8'h26,
        8'hA7, 8'hA8, 8'h29, 8'h2A,  // 32..35
        8'hAB, 8'h2C, 8'hAD, 8'hAE,
        8'h2F, 8'hB0, 8'h31, 8'h32,
        8'hB3, 8'h34, 8'hB5, 8'hB6,
        8'h37, 8'h38, 8'hB9, 8'hBA,  // 48..51
        8'h3B, 8'hBC, 8'h3D, 8'h3E,
        8'hBF, 8'hC1, 8'hC2, 8'h43,  // bit 6 only covers 57 and up
        8'hC4, 8'h45, 8'h46, 8'hC7,
        8'hC8, 8'h49, 8'h4A, 8'hCB   // 64..67
    };

    // ==========================================================
    // encoder
    // ==========================================================
    function automatic logic [PARITY_WIDTH-1:0] ecc68_encode(
        input logic [DATA_WIDTH-1:0] d
    );
        logic [PARITY_WIDTH-1:0] p;
        p = '0;
        // each set data bit toggles the parity bits named by its column
        for (int i = 0; i < DATA_WIDTH; i++) begin
            p = p ^ (H_COLUMNS[i] & {PARITY_WIDTH{d[i]}});
        end
        return p;
    endfunction

endpackage

`default_nettype wire

// File: src/ecc_err_log.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_err_log (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             rd_valid,
    input  wire logic                             rd_sbit,
    input  wire logic                             rd_dbit,
    input  wire logic [ecc68_pkg::ADDR_WIDTH-1:0] rd_err_addr,
    output logic      [ecc68_pkg::CNT_WIDTH-1:0]  sbit_count,
    output logic      [ecc68_pkg::CNT_WIDTH-1:0]  dbit_count,
    output logic      [ecc68_pkg::ADDR_WIDTH-1:0] last_err_addr
);

    import ecc68_pkg::*;

    logic sbit_full;
    logic dbit_full;

    assign sbit_full = (sbit_count == {CNT_WIDTH{1'b1}});   // saturate, never wrap
    assign dbit_full = (dbit_count == {CNT_WIDTH{1'b1}});

    always_ff @(posedge clk) begin
        if (rst) begin
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
        end else if (rd_valid) begin
            if (rd_sbit && !sbit_full) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (rd_dbit && !dbit_full) begin
                dbit_count <= dbit_count + 1'b1;
            end
            if (rd_sbit || rd_dbit) begin
                last_err_addr <= rd_err_addr;   // most recent error wins
            end
        end
    end

    // ==========================================================
    // checks
    // ==========================================================
    a_sbit_monotonic: assert property (
        @(posedge clk) disable iff (rst) !$past(rst) |-> (sbit_count >= $past(sbit_count))
    );

    a_dbit_monotonic: assert property (
        @(posedge clk) disable iff (rst) !$past(rst) |-> (dbit_count >= $past(dbit_count))
    );

endmodule

`default_nettype wire

// File: src/ecc_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_top (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             wr_en,
    input  wire logic [ecc68_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  wire logic [ecc68_pkg::DATA_WIDTH-1:0] wr_data,
    input  wire logic [ecc68_pkg::CODE_WIDTH-1:0] inj_flip,
    input  wire logic                             rd_en,
    input  wire logic [ecc68_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  wire logic                             ecc_bypass,
    output logic                                  rd_valid,
    output logic      [ecc68_pkg::DATA_WIDTH-1:0] rd_data,
    output logic                                  rd_sbit,
    output logic                                  rd_dbit,
    output logic      [ecc68_pkg::CNT_WIDTH-1:0]  sbit_count,
    output logic      [ecc68_pkg::CNT_WIDTH-1:0]  dbit_count,
    output logic      [ecc68_pkg::ADDR_WIDTH-1:0] last_err_addr
);

    import ecc68_pkg::*;

    logic [CODE_WIDTH-1:0] wr_code;
    logic [CODE_WIDTH-1:0] rd_code;
    logic [ADDR_WIDTH-1:0] rd_err_addr;

    // ==========================================================
    // write path with fault injection
    // ==========================================================
    assign wr_code = {ecc68_encode(wr_data), wr_data} ^ inj_flip;   // flips hit this write only

    ecc_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_code (wr_code),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_code (rd_code)
    );

    // ==========================================================
    // read path and error log
    // ==========================================================
    ecc_read_port u_read_port (
        .clk         (clk),
        .rst         (rst),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_code     (rd_code),
        .bypass      (ecc_bypass),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_sbit     (rd_sbit),
        .rd_dbit     (rd_dbit),
        .rd_err_addr (rd_err_addr)
    );

    ecc_err_log u_err_log (
        .clk           (clk),
        .rst           (rst),
        .rd_valid      (rd_valid),
        .rd_sbit       (rd_sbit),
        .rd_dbit       (rd_dbit),
        .rd_err_addr   (rd_err_addr),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

`default_nettype wire

// File: src/ecc_ram.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_ram (
    input  wire logic                             clk,
    input  wire logic                             wr_en,
    input  wire logic [ecc68_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  wire logic [ecc68_pkg::CODE_WIDTH-1:0] wr_code,
    input  wire logic                             rd_en,
    input  wire logic [ecc68_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic      [ecc68_pkg::CODE_WIDTH-1:0] rd_code
);

    import ecc68_pkg::*;

    logic [CODE_WIDTH-1:0] mem [0:MEM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_code;
        end
    end

    // read before write on a shared address, old word comes out
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_code <= mem[rd_addr];   // held until the next read
        end
    end

endmodule

`default_nettype wire

// File: src/ecc_read_port.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_read_port (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             rd_en,
    input  wire logic [ecc68_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  wire logic [ecc68_pkg::CODE_WIDTH-1:0] rd_code,
    input  wire logic                             bypass,
    output logic                                  rd_valid,
    output logic      [ecc68_pkg::DATA_WIDTH-1:0] rd_data,
    output logic                                  rd_sbit,
    output logic                                  rd_dbit,
    output logic      [ecc68_pkg::ADDR_WIDTH-1:0] rd_err_addr
);

    import ecc68_pkg::*;

    logic                  trk_valid;   // lines up with rd_code
    logic [ADDR_WIDTH-1:0] trk_addr;
    logic [DATA_WIDTH-1:0] fix_data;
    logic                  fix_sbit;
    logic                  fix_dbit;

    // ==========================================================
    // stage 1, track the request alongside the RAM read
    // ==========================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            trk_valid <= 1'b0;
        end else begin
            trk_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        trk_addr <= rd_addr;
    end

    ecc68_codec u_codec (
        .clk        (clk),
        .data_in    (rd_code[DATA_WIDTH-1:0]),
        .parity_in  (rd_code[CODE_WIDTH-1:DATA_WIDTH]),
        .bypass     (bypass),
        .data_out   (fix_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (fix_sbit),
        .dbit_err   (fix_dbit)
    );

    // ==========================================================
    // stage 2, output register
    // ==========================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_sbit  <= 1'b0;
            rd_dbit  <= 1'b0;
        end else begin
            rd_valid <= trk_valid;
            rd_sbit  <= trk_valid & fix_sbit;   // stale codeword must not flag
            rd_dbit  <= trk_valid & fix_dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (trk_valid) begin
            rd_data     <= fix_data;
            rd_err_addr <= trk_addr;
        end
    end

    a_flag_needs_valid: assert property (
        @(posedge clk) disable iff (rst) (rd_sbit || rd_dbit) |-> rd_valid
    );

endmodule

`default_nettype wire

// File: tb/tb_ecc_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ecc_mem;

    import ecc68_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 4000;   // roughly ten times the full test length

    logic                  clk;
    logic                  rst;
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [CODE_WIDTH-1:0] inj_flip;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  ecc_bypass;
    logic                  rd_valid;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_sbit;
    logic                  rd_dbit;
    logic [CNT_WIDTH-1:0]  sbit_count;
    logic [CNT_WIDTH-1:0]  dbit_count;
    logic [ADDR_WIDTH-1:0] last_err_addr;

    // reference model
    logic [DATA_WIDTH-1:0] shadow_data [0:MEM_DEPTH-1];
    logic [CODE_WIDTH-1:0] shadow_flip [0:MEM_DEPTH-1];   // flips stored with each word
    logic [CNT_WIDTH-1:0]  exp_sbit_cnt;
    logic [CNT_WIDTH-1:0]  exp_dbit_cnt;
    logic [ADDR_WIDTH-1:0] exp_last_addr;

    int     mismatch_count;
    int     other_errors;
    int     cycle_count;
    integer seed;

    ecc_mem_top dut (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .inj_flip      (inj_flip),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .ecc_bypass    (ecc_bypass),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_sbit       (rd_sbit),
        .rd_dbit       (rd_dbit),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ============================================================
    // model helpers
    // ============================================================
    // syndrome of an error pattern is the XOR of the columns it hits
    function automatic logic [PARITY_WIDTH-1:0] flip_syndrome(input logic [CODE_WIDTH-1:0] f);
        logic [PARITY_WIDTH-1:0] s;
        s = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (f[i]) s = s ^ H_COLUMNS[i];
        end
        for (int k = 0; k < PARITY_WIDTH; k++) begin
            if (f[DATA_WIDTH+k]) s[k] = ~s[k];   // check bits form the identity part
        end
        return s;
    endfunction

    function automatic int find_column(input logic [PARITY_WIDTH-1:0] s);
        int col;
        col = -1;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (H_COLUMNS[i] == s) col = i;
        end
        return col;
    endfunction

    task automatic make_word(output logic [DATA_WIDTH-1:0] w);
        logic [95:0] r;
        r = {$random(seed), $random(seed), $random(seed)};
        w = r[DATA_WIDTH-1:0];
    endtask

    task automatic predict_read(input logic [ADDR_WIDTH-1:0] a, output logic [DATA_WIDTH-1:0] d,
                                output logic s, output logic db);
        logic [PARITY_WIDTH-1:0] syn;
        int                      col;
        syn = flip_syndrome(shadow_flip[a]);
        col = find_column(syn);
        d   = shadow_data[a] ^ shadow_flip[a][DATA_WIDTH-1:0];   // word as stored
        s   = 1'b0;
        db  = 1'b0;
        if (!ecc_bypass) begin
            if (col >= 0) begin
                d[col] = ~d[col];
                s      = 1'b1;
            end else if ($onehot(syn)) begin
                s = 1'b1;
            end else if (syn != '0) begin
                db = 1'b1;
            end
        end
    endtask

    // ============================================================
    // driving and checking
    // ============================================================
    task automatic write_word(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d,
                              input logic [CODE_WIDTH-1:0] f);
        @(posedge clk);
        wr_en    <= 1'b1;
        wr_addr  <= a;
        wr_data  <= d;
        inj_flip <= f;
        @(posedge clk);
        wr_en    <= 1'b0;
        inj_flip <= '0;
        shadow_data[a] = d;
        shadow_flip[a] = f;
    endtask

    task automatic check_result(input logic [ADDR_WIDTH-1:0] a);
        logic [DATA_WIDTH-1:0] exp_data;
        logic                  exp_s;
        logic                  exp_d;
        predict_read(a, exp_data, exp_s, exp_d);
        if (exp_s) exp_sbit_cnt = exp_sbit_cnt + 1'b1;
        if (exp_d) exp_dbit_cnt = exp_dbit_cnt + 1'b1;
        if (exp_s || exp_d) exp_last_addr = a;
        if (rd_valid !== 1'b1) begin
            mismatch_count++;
            $display("MISMATCH at %0t: rd_valid low for read of addr %0d", $time, a);
        end
        if (!exp_d && rd_data !== exp_data) begin   // data after a double error is undefined
            mismatch_count++;
            $display("MISMATCH at %0t: addr %0d data %h, expected %h", $time, a, rd_data, exp_data);
        end
        if (rd_sbit !== exp_s || rd_dbit !== exp_d) begin
            mismatch_count++;
            $display("MISMATCH at %0t: addr %0d flags sbit %b dbit %b, expected %b %b",
                     $time, a, rd_sbit, rd_dbit, exp_s, exp_d);
        end
    endtask

    task automatic read_word(input logic [ADDR_WIDTH-1:0] a);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= a;
        @(posedge clk);
        rd_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_result(a);
    endtask

    // one read per cycle, each result checked two edges after its request
    task automatic read_burst(input logic [ADDR_WIDTH-1:0] first, input int n);
        logic [ADDR_WIDTH-1:0] addr;
        for (int c = 0; c < n + 2; c++) begin
            @(posedge clk);
            if (c < n) begin
                addr = first + ADDR_WIDTH'(c);
                rd_en   <= 1'b1;
                rd_addr <= addr;
            end else begin
                rd_en <= 1'b0;
            end
            @(negedge clk);
            if (c >= 2) check_result(first + ADDR_WIDTH'(c - 2));
        end
    endtask

    task automatic check_log();
        repeat (2) @(negedge clk);   // log updates one edge after rd_valid
        if (sbit_count !== exp_sbit_cnt || dbit_count !== exp_dbit_cnt) begin
            mismatch_count++;
            $display("MISMATCH at %0t: counts sbit %0d dbit %0d, expected %0d %0d",
                     $time, sbit_count, dbit_count, exp_sbit_cnt, exp_dbit_cnt);
        end
        if (last_err_addr !== exp_last_addr) begin
            mismatch_count++;
            $display("MISMATCH at %0t: last_err_addr %0d, expected %0d",
                     $time, last_err_addr, exp_last_addr);
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_reset_state();
        @(negedge clk);
        if (rd_valid !== 1'b0 || rd_sbit !== 1'b0 || rd_dbit !== 1'b0) begin
            mismatch_count++;
            $display("MISMATCH at %0t: read outputs not low after reset", $time);
        end
        check_log();
    endtask

    task automatic test_clean();
        logic [DATA_WIDTH-1:0] w;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            make_word(w);
            write_word(ADDR_WIDTH'(a), w, '0);
        end
        read_burst('0, MEM_DEPTH);
        read_word(6'd5);
        read_word(6'd63);
        check_log();
    endtask

    task automatic test_data_flip();
        int                    pos [0:4] = '{0, 1, 34, 66, 67};
        logic [DATA_WIDTH-1:0] w;
        logic [CODE_WIDTH-1:0] f;
        for (int i = 0; i < 5; i++) begin
            make_word(w);
            f         = '0;
            f[pos[i]] = 1'b1;
            write_word(ADDR_WIDTH'(8 + i), w, f);
            read_word(ADDR_WIDTH'(8 + i));
            check_log();
        end
    endtask

    task automatic test_check_flip();
        logic [DATA_WIDTH-1:0] w;
        logic [CODE_WIDTH-1:0] f;
        for (int k = 0; k < PARITY_WIDTH; k++) begin
            make_word(w);
            f                 = '0;
            f[DATA_WIDTH + k] = 1'b1;
            write_word(ADDR_WIDTH'(16 + k), w, f);
            read_word(ADDR_WIDTH'(16 + k));
        end
        check_log();
    endtask

    task automatic test_double_flip();
        int                      bit_a [0:3] = '{3, 0, 68, 10};
        int                      bit_b [0:3] = '{40, 70, 75, 67};
        logic [DATA_WIDTH-1:0]   w;
        logic [CODE_WIDTH-1:0]   f;
        logic [PARITY_WIDTH-1:0] syn;
        for (int i = 0; i < 4; i++) begin
            f           = '0;
            f[bit_a[i]] = 1'b1;
            f[bit_b[i]] = 1'b1;
            syn         = flip_syndrome(f);
            if (syn == '0 || $onehot(syn) || find_column(syn) >= 0) begin
                other_errors++;
                $display("bits %0d and %0d do not give a double-bit syndrome", bit_a[i], bit_b[i]);
            end
            make_word(w);
            write_word(ADDR_WIDTH'(30 + i), w, f);
            read_word(ADDR_WIDTH'(30 + i));
            check_log();
        end
    endtask

    task automatic test_bypass();
        logic [DATA_WIDTH-1:0] w;
        logic [CODE_WIDTH-1:0] f;
        make_word(w);
        f     = '0;
        f[20] = 1'b1;
        write_word(6'd50, w, f);
        @(posedge clk);
        ecc_bypass <= 1'b1;
        read_word(6'd50);   // raw word with the flip, no flags
        @(posedge clk);
        ecc_bypass <= 1'b0;
        check_log();
        read_word(6'd50);   // corrected again once bypass drops
        check_log();
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        seed           = 32'h418;
        rst            = 1'b1;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        inj_flip       = '0;
        rd_en          = 1'b0;
        rd_addr        = '0;
        ecc_bypass     = 1'b0;
        exp_sbit_cnt   = '0;
        exp_dbit_cnt   = '0;
        exp_last_addr  = '0;
        mismatch_count = 0;
        other_errors   = 0;
        cycle_count    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_clean();
        test_data_flip();
        test_check_flip();
        test_double_flip();
        test_bypass();

        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
